/* Bender.yml */
package:
  name: dma_ctrl

sources:
  - include_dirs:
      - include
    files:
      - verilog/dma_pkg.sv
      - verilog/dma_csr.sv
      - verilog/dma_desc_ctrl.sv
      - verilog/dma_wb_master.sv
      - verilog/dma_job_regs.sv
      - verilog/dma_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/dma_ctrl_checker.sv
      - verif/dma_ctrl_tb.sv

/* include/dma_defines.svh */
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// beats per Wishbone burst, 64 bits each
`define DMA_BEATS 4

// descriptor control word
`define DMA_DC_W    24
`define DMA_DC_STAT 7    // write status record when done
`define DMA_DC_LINK 14   // follow next pointer
`define DMA_DC_IRQ  15   // interrupt on completion

// descriptor beats holding fields of interest
`define DMA_DB_LINK 2'd0   // next pointer low, status address high
`define DMA_DB_CTRL 2'd1   // control word in low 24 bits

// status record beats
`define DMA_ST_OCNT       2'd0
`define DMA_ST_ERR        2'd1
`define DMA_ST_CYC        2'd2
`define DMA_ST_DC         2'd3
`define DMA_ST_OCNT_SHIFT 3   // engine count is in 8-byte units

`endif

/* verif/dma_ctrl_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_checker (
   input wire        clk_i,
   input wire        rst_i,
   input wire        cyc_i,
   input wire        stb_i,
   input wire        ack_i,
   input wire        err_i,
   input wire        rty_i,
   input wire        cab_i,
   input wire [7:0]  sel_i,
   input wire [31:0] adr_i,
   input wire        ss_we_i,
   input wire        ss_done_i,
   input wire        m_enable_i,
   input wire        m_reset_i,
   input wire        busy_i
);

   int unsigned fail_cnt = 0;   // read by the testbench at the end
   logic        accept;

   assign accept = cyc_i && ack_i && !err_i && !rty_i;

   stb_follows_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i == cyc_i)
      else begin
         $error("wishbone stb differs from cyc");
         fail_cnt++;
      end

   burst_attrs: assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_i |-> cab_i && sel_i == 8'hff)
      else begin
         $error("burst without cab or full sel");
         fail_cnt++;
      end

   // a beat without a clean ack stays where it is
   beat_held: assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_i && !accept |=> cyc_i && $stable(adr_i))
      else begin
         $error("burst moved or ended on a beat that was not acked");
         fail_cnt++;
      end

   load_while_stopped: assert property (@(posedge clk_i) disable iff (rst_i)
      ss_we_i |-> !m_enable_i)
      else begin
         $error("engine job written while engines run");
         fail_cnt++;
      end

   done_then_reset: assert property (@(posedge clk_i) disable iff (rst_i)
      ss_done_i |=> m_reset_i && !ss_done_i)
      else begin
         $error("ss_done not a single pulse followed by m_reset");
         fail_cnt++;
      end

   idle_no_burst: assert property (@(posedge clk_i) disable iff (rst_i)
      !busy_i |-> !cyc_i)
      else begin
         $error("wishbone cycle while controller idle");
         fail_cnt++;
      end

endmodule

bind dma_ctrl_top dma_ctrl_checker u_checker (
   .clk_i(wb_clk_i), .rst_i(wb_rst_i), .cyc_i(wbm_cyc_o), .stb_i(wbm_stb_o),
   .ack_i(wbm_ack_i), .err_i(wbm_err_i), .rty_i(wbm_rty_i), .cab_i(wbm_cab_o),
   .sel_i(wbm_sel_o), .adr_i(wbm_adr_o), .ss_we_i(ss_we_o), .ss_done_i(ss_done_o),
   .m_enable_i(m_enable_o), .m_reset_i(m_reset_o), .busy_i(busy_o)
);

`default_nettype wire

/* verif/dma_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dma_defines.svh"

module dma_ctrl_tb;

   localparam int CYCLE_LIMIT = 4000;   // nine jobs under 100 cycles each, wide margin

   logic                 wb_clk_i  = 1'b0;
   logic                 wb_rst_i  = 1'b1;
   logic                 reg_we_i  = 1'b0;
   logic [1:0]           reg_adr_i = 2'd0;
   logic [31:0]          reg_dat_i = 32'd0;
   logic                 wbm_ack_i = 1'b0;
   logic                 wbm_err_i = 1'b0;
   logic                 wbm_rty_i = 1'b0;
   logic [63:0]          wbm_dat_i = 64'd0;
   logic [1:0]           c_done_i  = 2'b00;
   logic [15:0]          ocnt_i    = 16'd0;
   logic                 wbm_cyc_o;
   logic                 wbm_stb_o;
   logic                 wbm_we_o;
   logic                 wbm_cab_o;
   logic [7:0]           wbm_sel_o;
   logic [31:0]          wbm_adr_o;
   logic [63:0]          wbm_dat_o;
   logic                 ss_we_o;
   logic [1:0]           ss_adr_o;
   logic [31:0]          ss_dat_o;
   logic [`DMA_DC_W-1:0] ss_dc_o;
   logic                 ss_done_o;
   logic                 m_enable_o;
   logic                 m_reset_o;
   logic                 irq_o;
   logic [31:0]          dar_o;
   logic                 busy_o;

   logic [63:0] mem [0:255];   // 8-byte words, byte address bits 10:3
   logic [33:0] ss_q[$];       // index and data seen by the engines
   logic [31:0] rd_q[$];
   logic [95:0] wr_q[$];       // address and data of written beats
   int          ss_done_cnt = 0;
   int          rty_inject = 0;
   int          delay_left = 0;
   bit          pending = 1'b0;
   int          eng_cnt = 0;
   int          eng_delay = 0;
   int          cycles = 0;
   int          errors = 0;
   int          checks = 0;

   dma_ctrl_top u_dma_ctrl_top (.*);

   initial begin
      forever #10 wb_clk_i = ~wb_clk_i;
   end

   // memory slave, new ack delay per beat
   always @(negedge wb_clk_i) begin
      wbm_ack_i = 1'b0;
      wbm_rty_i = 1'b0;
      if (!wbm_cyc_o) begin
         pending = 1'b0;
      end else begin
         if (!pending) begin
            pending    = 1'b1;
            delay_left = $urandom_range(3, 0);
         end
         if (delay_left > 0) begin
            delay_left--;
         end else if (rty_inject > 0) begin
            wbm_rty_i = 1'b1;          // master must repeat this beat
            rty_inject--;
         end else begin
            wbm_ack_i = 1'b1;
            wbm_dat_i = mem[wbm_adr_o[10:3]];
            pending   = 1'b0;
         end
      end
   end

   // both copy engines finish together
   always @(negedge wb_clk_i) begin
      if (!m_enable_o) begin
         c_done_i = 2'b00;
         eng_cnt  = 0;
      end else begin
         if (eng_cnt == 0)
            eng_delay = $urandom_range(20, 5);
         eng_cnt++;
         if (eng_cnt >= eng_delay)
            c_done_i = 2'b11;
      end
   end

   always @(posedge wb_clk_i) begin
      if (!wb_rst_i) begin
         if (ss_we_o)
            ss_q.push_back({ss_adr_o, ss_dat_o});
         if (ss_done_o)
            ss_done_cnt++;
         if (wbm_cyc_o && wbm_ack_i && !wbm_err_i && !wbm_rty_i) begin
            if (wbm_we_o) begin
               mem[wbm_adr_o[10:3]] = wbm_dat_o;
               wr_q.push_back({wbm_adr_o, wbm_dat_o});
            end else begin
               rd_q.push_back(wbm_adr_o);
            end
         end
      end
   end

   always @(posedge wb_clk_i) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("run stopped after %0d cycles, controller never went idle", cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic expect_eq(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic require(input bit cond, input string what);
      checks++;
      assert (cond) else begin
         errors++;
         $display("%0t: %s", $time, what);
      end
   endtask

   task automatic reg_write(input logic [1:0] adr, input logic [31:0] dat);
      @(negedge wb_clk_i);
      reg_we_i  = 1'b1;
      reg_adr_i = adr;
      reg_dat_i = dat;
      @(negedge wb_clk_i);
      reg_we_i  = 1'b0;
   endtask

   // beat 0 holds both pointers, beat 1 the control word
   task automatic put_desc(input int w, input int next_w, input int stat_w,
                           input logic [23:0] dc);
      mem[w]     = {32'(stat_w * 8), 32'(next_w * 8)};
      mem[w + 1] = {mem[w + 1][63:32], 8'h00, dc};
   endtask

   task automatic clear_logs();
      ss_q.delete();
      rd_q.delete();
      wr_q.delete();
      ss_done_cnt = 0;
   endtask

   task automatic wait_job();
      @(negedge wb_clk_i);
      while (!busy_o)
         @(negedge wb_clk_i);
      while (busy_o)
         @(negedge wb_clk_i);
   endtask

   task automatic check_beats(input int first, input int w);
      int k;
      require(ss_q.size() >= first + 4, "engines missed descriptor beats");
      if (ss_q.size() >= first + 4) begin
         for (k = 0; k < 4; k++) begin
            expect_eq("ss_adr_o", ss_q[first + k][33:32], k);
            expect_eq("ss_dat_o", ss_q[first + k][31:0], mem[w + k][31:0]);
         end
      end
   endtask

   task automatic check_reads(input int first, input int w);
      int k;
      require(rd_q.size() >= first + 4, "descriptor fetch has too few beats");
      if (rd_q.size() >= first + 4) begin
         for (k = 0; k < 4; k++)
            expect_eq("wbm_adr_o", rd_q[first + k], (w + k) * 8);
      end
   endtask

   task automatic single_desc();
      put_desc(8, 0, 0, 24'h000000);
      clear_logs();
      reg_write(2'd0, 32'(8 * 8));
      reg_write(2'd1, 32'h1);
      wait_job();
      check_beats(0, 8);
      check_reads(0, 8);
      expect_eq("ss_q size", ss_q.size(), 4);
      expect_eq("ss_done_o pulses", ss_done_cnt, 1);
      @(negedge wb_clk_i);
      expect_eq("busy_o", busy_o, 0);   // no second fetch once the request is served
      expect_eq("dar_o", dar_o, 8 * 8);
      require(wr_q.size() == 0, "unexpected Wishbone write in a job without status");
   endtask

   task automatic status_writeback();
      int k;
      logic [23:0] dc;
      dc = 24'h030000 | (24'd1 << `DMA_DC_STAT);
      ocnt_i = 16'h0123;
      put_desc(16, 0, 100, dc);
      clear_logs();
      reg_write(2'd0, 32'(16 * 8));
      wait_job();
      check_beats(0, 16);
      expect_eq("ss_dc_o", ss_dc_o, dc);
      require(wr_q.size() == 4, "status record was not written as four beats");
      if (wr_q.size() == 4) begin
         for (k = 0; k < 4; k++)
            expect_eq("status wbm_adr_o", wr_q[k][95:64], (100 + k) * 8);
         expect_eq("status ocnt", wr_q[0][63:0], 64'(ocnt_i) << 3);
         expect_eq("status beat 1", wr_q[1][63:0], 0);
         expect_eq("status cycles high word", wr_q[2][63:32], 0);
         require(wr_q[2][31:0] >= eng_delay, "job cycle count below engine delay");
         expect_eq("status control word", wr_q[3][63:0], 64'(dc));
      end
   endtask

   task automatic chain_three();
      logic [23:0] link_dc;
      link_dc = 24'd1 << `DMA_DC_LINK;
      put_desc(24, 28, 0, link_dc);
      put_desc(28, 32, 0, link_dc);
      put_desc(32, 0, 0, 24'h000000);
      clear_logs();
      reg_write(2'd0, 32'(24 * 8));
      wait_job();
      check_beats(0, 24);
      check_beats(4, 28);
      check_beats(8, 32);
      check_reads(8, 32);
      expect_eq("ss_done_o pulses", ss_done_cnt, 3);
      expect_eq("dar_o", dar_o, 32 * 8);
   endtask

   task automatic irq_raise_clear();
      put_desc(40, 0, 0, 24'd1 << `DMA_DC_IRQ);
      clear_logs();
      expect_eq("irq_o before job", irq_o, 0);
      reg_write(2'd0, 32'(40 * 8));
      wait_job();
      expect_eq("irq_o after job", irq_o, 1);
      reg_write(2'd2, 32'h1);
      expect_eq("irq_o after clear", irq_o, 0);
   endtask

   task automatic append_relink();
      put_desc(48, 52, 0, 24'h000000);
      put_desc(52, 0, 0, 24'h000000);
      clear_logs();
      reg_write(2'd0, 32'(48 * 8));
      wait_job();
      expect_eq("dar_o", dar_o, 48 * 8);
      mem[49][`DMA_DC_LINK] = 1'b1;     // software adds the link late
      clear_logs();
      reg_write(2'd1, 32'h3);
      wait_job();
      expect_eq("ss_q size", ss_q.size(), 4);
      check_beats(0, 52);
      check_reads(0, 48);
      check_reads(4, 52);
      expect_eq("ss_done_o pulses", ss_done_cnt, 1);
      expect_eq("dar_o", dar_o, 52 * 8);
   endtask

   task automatic back_pressure();
      put_desc(60, 0, 0, 24'h000000);
      clear_logs();
      rty_inject = 2;
      reg_write(2'd0, 32'(60 * 8));
      wait_job();
      require(rty_inject == 0, "retry responses were never issued");
      expect_eq("ss_q size", ss_q.size(), 4);
      expect_eq("rd_q size", rd_q.size(), 4);
      check_beats(0, 60);
      check_reads(0, 60);
      expect_eq("ss_done_o pulses", ss_done_cnt, 1);
      expect_eq("dar_o", dar_o, 60 * 8);
      require(wr_q.size() == 0, "unexpected Wishbone write under back-pressure");
   endtask

   initial begin
      int i;
      int asrt_fails;
      void'($urandom(32'h6306aece));
      for (i = 0; i < 256; i++)
         mem[i] = {32'hc0de0000 ^ 32'(i), 32'(i) * 32'h01000193 + 32'h5bd1e995};
      repeat (5) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;
      single_desc();
      status_writeback();
      chain_three();
      irq_raise_clear();
      append_relink();
      back_pressure();
      asrt_fails = u_dma_ctrl_top.u_checker.fail_cnt;
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
      if (errors == 0 && asrt_fails == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/dma_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_csr (
   input  wire              wb_clk_i,
   input  wire              wb_rst_i,
   input  wire              reg_we_i,
   input  wire [1:0]        reg_adr_i,
   input  wire [31:0]       reg_dat_i,
   input  wire              dirty_clear_i,
   input  wire              append_clear_i,
   input  wire              irq_set_i,
   input  wire [28:0]       done_dar_i,
   output dma_pkg::csr_t    csr_o,
   output logic [31:0]      dar_o,
   output logic             irq_o
);

   logic [28:0] ndar_q;
   logic        dirty_q;
   logic        enable_q;
   logic        append_q;
   logic        irq_clr;

   assign irq_clr = reg_we_i && reg_adr_i == 2'd2 && reg_dat_i[0];

   always_ff @(posedge wb_clk_i) begin
      if (reg_we_i && reg_adr_i == 2'd0)
         ndar_q <= reg_dat_i[31:3];
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         dirty_q  <= 1'b0;
         enable_q <= 1'b0;
         append_q <= 1'b0;
         irq_o    <= 1'b0;
      end else begin
         if (reg_we_i && reg_adr_i == 2'd0)
            dirty_q <= 1'b1;            // a new write beats the clear
         else if (dirty_clear_i)
            dirty_q <= 1'b0;
         if (reg_we_i && reg_adr_i == 2'd1)
            enable_q <= reg_dat_i[0];
         if (reg_we_i && reg_adr_i == 2'd1 && reg_dat_i[1])
            append_q <= 1'b1;
         else if (append_clear_i)
            append_q <= 1'b0;
         case ({irq_clr, irq_set_i})
            2'b01:   irq_o <= 1'b1;
            2'b10:   irq_o <= 1'b0;
            default: irq_o <= irq_o;    // set and clear together hold
         endcase
      end
   end

   assign csr_o.enable     = enable_q;
   assign csr_o.ndar_dirty = dirty_q;
   assign csr_o.append     = append_q;
   assign csr_o.ndar       = ndar_q;

   assign dar_o = {done_dar_i, 3'b000};   // byte address of last job

endmodule

`default_nettype wire

/* verilog/dma_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dma_defines.svh"

module dma_ctrl_top (
   input  wire                   wb_clk_i,
   input  wire                   wb_rst_i,
   input  wire                   reg_we_i,
   input  wire [1:0]             reg_adr_i,
   input  wire [31:0]            reg_dat_i,
   input  wire                   wbm_ack_i,
   input  wire                   wbm_err_i,
   input  wire                   wbm_rty_i,
   input  wire [63:0]            wbm_dat_i,
   output logic                  wbm_cyc_o,
   output logic                  wbm_stb_o,
   output logic                  wbm_we_o,
   output logic                  wbm_cab_o,
   output logic [7:0]            wbm_sel_o,
   output logic [31:0]           wbm_adr_o,
   output logic [63:0]           wbm_dat_o,
   input  wire [1:0]             c_done_i,
   input  wire [15:0]            ocnt_i,
   output logic                  ss_we_o,
   output logic [1:0]            ss_adr_o,
   output logic [31:0]           ss_dat_o,
   output logic [`DMA_DC_W-1:0]  ss_dc_o,
   output logic                  ss_done_o,
   output logic                  m_enable_o,
   output logic                  m_reset_o,
   output logic                  irq_o,
   output logic [31:0]           dar_o,
   output logic                  busy_o
);

   dma_pkg::csr_t       csr;
   dma_pkg::burst_req_t req;
   dma_pkg::beat_t      beat;
   dma_pkg::job_t       job;
   logic                dirty_clear;
   logic                append_clear;
   logic                irq_set;
   logic [28:0]         done_dar;
   logic                burst_done;
   logic                load_en;
   logic                job_start;
   logic                job_end;
   logic [63:0]         stat;          // status beat to write

   dma_csr u_csr (
      .wb_clk_i, .wb_rst_i, .reg_we_i, .reg_adr_i, .reg_dat_i,
      .dirty_clear_i(dirty_clear), .append_clear_i(append_clear),
      .irq_set_i(irq_set), .done_dar_i(done_dar),
      .csr_o(csr), .dar_o, .irq_o
   );

   dma_desc_ctrl u_desc_ctrl (
      .wb_clk_i, .wb_rst_i, .csr_i(csr), .beat_i(beat),
      .burst_done_i(burst_done), .job_i(job), .c_done_i, .req_o(req),
      .load_en_o(load_en), .job_start_o(job_start), .job_end_o(job_end),
      .dirty_clear_o(dirty_clear), .append_clear_o(append_clear),
      .irq_set_o(irq_set), .done_dar_o(done_dar), .busy_o
   );

   dma_wb_master u_wb_master (
      .wb_clk_i, .wb_rst_i, .req_i(req), .wdata_i(stat),
      .wbm_ack_i, .wbm_err_i, .wbm_rty_i, .wbm_dat_i,
      .wbm_cyc_o, .wbm_stb_o, .wbm_we_o, .wbm_cab_o, .wbm_sel_o,
      .wbm_adr_o, .wbm_dat_o, .beat_o(beat), .burst_done_o(burst_done)
   );

   dma_job_regs u_job_regs (
      .wb_clk_i, .wb_rst_i, .beat_i(beat), .load_en_i(load_en),
      .job_start_i(job_start), .job_end_i(job_end), .ocnt_i,
      .job_o(job), .ss_we_o, .ss_adr_o, .ss_dat_o, .ss_dc_o, .ss_done_o,
      .m_enable_o, .m_reset_o, .stat_o(stat)
   );

endmodule

`default_nettype wire

/* verilog/dma_desc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dma_defines.svh"

module dma_desc_ctrl (
   input  wire                   wb_clk_i,
   input  wire                   wb_rst_i,
   input  wire dma_pkg::csr_t    csr_i,
   input  wire dma_pkg::beat_t   beat_i,
   input  wire                   burst_done_i,
   input  wire dma_pkg::job_t    job_i,
   input  wire [1:0]             c_done_i,
   output dma_pkg::burst_req_t   req_o,
   output logic                  load_en_o,
   output logic                  job_start_o,
   output logic                  job_end_o,
   output logic                  dirty_clear_o,
   output logic                  append_clear_o,
   output logic                  irq_set_o,
   output logic [28:0]           done_dar_o,
   output logic                  busy_o
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_DECIDE,
      S_WAIT,
      S_STATUS,
      S_FINISH
   } state_e;

   state_e      state_q;
   state_e      state_d;
   logic        append_q;
   logic        append_d;
   logic        start_q;
   logic        start_d;
   logic        we_q;
   logic        we_d;
   logic [28:0] adr_q;
   logic [28:0] adr_d;
   logic        dclr_d;
   logic        aclr_d;
   logic [28:0] cdar_q;        // descriptor being processed
   logic [28:0] app_next_q;
   logic        app_link_q;
   logic        link;
   logic [28:0] next_ptr;

   // append re-read leaves job registers alone, so link comes from here
   assign link     = append_q ? app_link_q : job_i.dc[`DMA_DC_LINK];
   assign next_ptr = append_q ? app_next_q : job_i.next_desc;

   always_comb begin
      state_d  = state_q;
      append_d = append_q;
      start_d  = 1'b0;
      we_d     = 1'b0;
      adr_d    = adr_q;
      dclr_d   = 1'b0;
      aclr_d   = 1'b0;
      case (state_q)
         S_IDLE: begin
            if (csr_i.enable && csr_i.ndar_dirty) begin
               start_d = 1'b1;
               adr_d   = csr_i.ndar;
               dclr_d  = 1'b1;
               state_d = S_FETCH;
            end else if (csr_i.enable && csr_i.append) begin
               start_d  = 1'b1;
               adr_d    = done_dar_o;   // last completed descriptor
               aclr_d   = 1'b1;
               append_d = 1'b1;
               state_d  = S_FETCH;
            end
         end
         S_FETCH: begin
            if (burst_done_i)
               state_d = append_q ? S_FINISH : S_DECIDE;
         end
         S_DECIDE: state_d = S_WAIT;    // engines start here
         S_WAIT: begin
            if (&c_done_i) begin
               if (job_i.dc[`DMA_DC_STAT]) begin
                  start_d = 1'b1;
                  we_d    = 1'b1;
                  adr_d   = job_i.stat_adr;
                  state_d = S_STATUS;
               end else begin
                  state_d = S_FINISH;
               end
            end
         end
         S_STATUS: begin
            if (burst_done_i)
               state_d = S_FINISH;
         end
         S_FINISH: begin
            append_d = 1'b0;
            if (link) begin
               start_d = 1'b1;
               adr_d   = next_ptr;
               state_d = S_FETCH;
            end else begin
               state_d = S_IDLE;
            end
         end
         default: state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q        <= S_IDLE;
         append_q       <= 1'b0;
         start_q        <= 1'b0;
         we_q           <= 1'b0;
         dirty_clear_o  <= 1'b0;
         append_clear_o <= 1'b0;
         done_dar_o     <= 29'd0;
      end else begin
         state_q        <= state_d;
         append_q       <= append_d;
         start_q        <= start_d;
         we_q           <= we_d;
         dirty_clear_o  <= dclr_d;
         append_clear_o <= aclr_d;
         if (job_end_o)
            done_dar_o <= cdar_q;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      adr_q <= adr_d;
      if (start_d && !we_d)
         cdar_q <= adr_d;               // remember fetch address
      if (beat_i.valid && state_q == S_FETCH && append_q) begin
         if (beat_i.idx == `DMA_DB_LINK)
            app_next_q <= beat_i.data[31:3];
         if (beat_i.idx == `DMA_DB_CTRL)
            app_link_q <= beat_i.data[`DMA_DC_LINK];
      end
   end

   assign req_o.start = start_q;
   assign req_o.we    = we_q;
   assign req_o.adr   = adr_q;

   assign load_en_o   = state_q == S_FETCH && !append_q;
   assign job_start_o = state_q == S_DECIDE;
   assign job_end_o   = state_q == S_FINISH && !append_q;
   assign irq_set_o   = job_end_o && job_i.dc[`DMA_DC_IRQ];
   assign busy_o      = state_q != S_IDLE;

endmodule

`default_nettype wire

/* verilog/dma_job_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dma_defines.svh"

module dma_job_regs (
   input  wire                    wb_clk_i,
   input  wire                    wb_rst_i,
   input  wire dma_pkg::beat_t    beat_i,
   input  wire                    load_en_i,
   input  wire                    job_start_i,
   input  wire                    job_end_i,
   input  wire [15:0]             ocnt_i,
   output dma_pkg::job_t          job_o,
   output logic                   ss_we_o,
   output logic [1:0]             ss_adr_o,
   output logic [31:0]            ss_dat_o,
   output logic [`DMA_DC_W-1:0]   ss_dc_o,
   output logic                   ss_done_o,
   output logic                   m_enable_o,
   output logic                   m_reset_o,
   output logic [63:0]            stat_o
);

   logic [28:0]          next_q;
   logic [28:0]          stat_adr_q;
   logic [`DMA_DC_W-1:0] dc_q;
   logic [31:0]          cyc_cnt_q;     // job length in clocks
   logic                 load;

   assign load = beat_i.valid && load_en_i;

   always_ff @(posedge wb_clk_i) begin
      if (load && beat_i.idx == `DMA_DB_LINK) begin
         next_q     <= beat_i.data[31:3];
         stat_adr_q <= beat_i.data[63:35];
      end
      if (load && beat_i.idx == `DMA_DB_CTRL)
         dc_q <= beat_i.data[`DMA_DC_W-1:0];
      if (job_start_i)
         cyc_cnt_q <= 32'd0;
      else if (m_enable_o)
         cyc_cnt_q <= cyc_cnt_q + 32'd1;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         m_enable_o <= 1'b0;
         m_reset_o  <= 1'b1;
      end else begin
         m_reset_o <= job_end_i;        // one clock after each job
         if (job_start_i)
            m_enable_o <= 1'b1;
         else if (job_end_i)
            m_enable_o <= 1'b0;
      end
   end

   always_comb begin
      case (beat_i.idx)
         `DMA_ST_OCNT: stat_o = {48'd0, ocnt_i} << `DMA_ST_OCNT_SHIFT;
         `DMA_ST_ERR:  stat_o = 64'd0;  // errors not tracked
         `DMA_ST_CYC:  stat_o = {32'd0, cyc_cnt_q};
         `DMA_ST_DC:   stat_o = {{(64 - `DMA_DC_W){1'b0}}, dc_q};
         default:      stat_o = 64'd0;
      endcase
   end

   // every fetched beat goes to both engines
   assign ss_we_o   = load;
   assign ss_adr_o  = beat_i.idx;
   assign ss_dat_o  = beat_i.data[31:0];
   assign ss_dc_o   = dc_q;
   assign ss_done_o = job_end_i;

   assign job_o.next_desc = next_q;
   assign job_o.stat_adr  = stat_adr_q;
   assign job_o.dc        = dc_q;

endmodule

`default_nettype wire

/* verilog/dma_pkg.sv */
`default_nettype none
`include "dma_defines.svh"

package dma_pkg;

   // software view of the register port
   typedef struct packed {
      logic        enable;
      logic        ndar_dirty;     // new chain head written
      logic        append;         // re-read last descriptor
      logic [28:0] ndar;           // 8-byte aligned address
   } csr_t;

   // one burst request toward the Wishbone master
   typedef struct packed {
      logic        start;          // single cycle pulse
      logic        we;
      logic [28:0] adr;
   } burst_req_t;

   // accepted beat reported by the Wishbone master
   typedef struct packed {
      logic        valid;
      logic [1:0]  idx;
      logic [63:0] data;
   } beat_t;

   // fields of the loaded descriptor
   typedef struct packed {
      logic [28:0]           next_desc;
      logic [28:0]           stat_adr;
      logic [`DMA_DC_W-1:0]  dc;
   } job_t;

endpackage

`default_nettype wire

/* verilog/dma_wb_master.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dma_defines.svh"

module dma_wb_master (
   input  wire                        wb_clk_i,
   input  wire                        wb_rst_i,
   input  wire dma_pkg::burst_req_t   req_i,
   input  wire [63:0]                 wdata_i,
   input  wire                        wbm_ack_i,
   input  wire                        wbm_err_i,
   input  wire                        wbm_rty_i,
   input  wire [63:0]                 wbm_dat_i,
   output logic                       wbm_cyc_o,
   output logic                       wbm_stb_o,
   output logic                       wbm_we_o,
   output logic                       wbm_cab_o,
   output logic [7:0]                 wbm_sel_o,
   output logic [31:0]                wbm_adr_o,
   output logic [63:0]                wbm_dat_o,
   output dma_pkg::beat_t             beat_o,
   output logic                       burst_done_o
);

   logic [28:0] adr_q;
   logic [1:0]  cnt_q;
   logic        cyc_q;
   logic        we_q;
   logic        accept;
   logic        last;

   // err or rty leave address and counter where they are
   assign accept = cyc_q && wbm_ack_i && !wbm_err_i && !wbm_rty_i;
   assign last   = cnt_q == 2'(`DMA_BEATS - 1);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         cyc_q <= 1'b0;
         we_q  <= 1'b0;
         cnt_q <= 2'd0;
      end else if (req_i.start) begin
         cyc_q <= 1'b1;
         we_q  <= req_i.we;
         cnt_q <= 2'd0;
      end else if (accept) begin
         cnt_q <= cnt_q + 2'd1;
         if (last)
            cyc_q <= 1'b0;              // drop on final beat
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (req_i.start)
         adr_q <= req_i.adr;
      else if (accept)
         adr_q <= adr_q + 29'd1;        // next 8-byte word
   end

   assign wbm_cyc_o = cyc_q;
   assign wbm_stb_o = cyc_q;            // no idle beats inside a burst
   assign wbm_we_o  = we_q;
   assign wbm_cab_o = 1'b1;
   assign wbm_sel_o = 8'hff;
   assign wbm_adr_o = {adr_q, 3'b000};
   assign wbm_dat_o = wdata_i;

   assign beat_o.valid = accept;
   assign beat_o.idx   = cnt_q;
   assign beat_o.data  = wbm_dat_i;

   assign burst_done_o = accept && last;

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
verilog/dma_pkg.sv
verilog/dma_csr.sv
verilog/dma_desc_ctrl.sv
verilog/dma_wb_master.sv
verilog/dma_job_regs.sv
verilog/dma_ctrl_top.sv
verif/dma_ctrl_checker.sv
verif/dma_ctrl_tb.sv
